/* common/gtiaPkg.sv */
//**************************************************
// GTIA shared types, ANTIC codes and register map
//**************************************************
package gtiaPkg;

  typedef logic [7:0] colorT;
  typedef logic [7:0] hposT;
  typedef logic [2:0] anCodeT;
  typedef logic [4:0] regAddrT;
  // 00 and 10 are 1x, 01 is 2x, 11 is 4x
  typedef logic [1:0] sizeT;

  // ANTIC playfield codes
  localparam anCodeT anBackground = 3'b000;
  localparam anCodeT anVsync      = 3'b001;
  localparam anCodeT anHsync      = 3'b010;
  localparam anCodeT anBlank      = 3'b011;
  localparam anCodeT anPf0        = 3'b100;
  localparam anCodeT anPf1        = 3'b101;
  localparam anCodeT anPf2        = 3'b110;
  localparam anCodeT anPf3        = 3'b111;

  // Write map
  localparam regAddrT addrHposP0 = 5'h00;
  localparam regAddrT addrHposP1 = 5'h01;
  localparam regAddrT addrHposP2 = 5'h02;
  localparam regAddrT addrHposP3 = 5'h03;
  localparam regAddrT addrHposM0 = 5'h04;
  localparam regAddrT addrHposM1 = 5'h05;
  localparam regAddrT addrHposM2 = 5'h06;
  localparam regAddrT addrHposM3 = 5'h07;
  localparam regAddrT addrSizeP0 = 5'h08;
  localparam regAddrT addrSizeP1 = 5'h09;
  localparam regAddrT addrSizeP2 = 5'h0A;
  localparam regAddrT addrSizeP3 = 5'h0B;
  localparam regAddrT addrSizeM  = 5'h0C;
  localparam regAddrT addrGrafP0 = 5'h0D;
  localparam regAddrT addrGrafP1 = 5'h0E;
  localparam regAddrT addrGrafP2 = 5'h0F;
  localparam regAddrT addrGrafP3 = 5'h10;
  localparam regAddrT addrGrafM  = 5'h11;
  localparam regAddrT addrColPm0 = 5'h12;
  localparam regAddrT addrColPm1 = 5'h13;
  localparam regAddrT addrColPm2 = 5'h14;
  localparam regAddrT addrColPm3 = 5'h15;
  localparam regAddrT addrColPf0 = 5'h16;
  localparam regAddrT addrColPf1 = 5'h17;
  localparam regAddrT addrColPf2 = 5'h18;
  localparam regAddrT addrColPf3 = 5'h19;
  localparam regAddrT addrColBk  = 5'h1A;
  localparam regAddrT addrPrior  = 5'h1B;
  localparam regAddrT addrHitClr = 5'h1E;

  // Read map, collision groups of four
  localparam regAddrT addrM0Pf   = 5'h00;
  localparam regAddrT addrP0Pf   = 5'h04;
  localparam regAddrT addrM0Pl   = 5'h08;
  localparam regAddrT addrP0Pl   = 5'h0C;
  localparam regAddrT addrTrig0  = 5'h10;
  localparam regAddrT addrTrig1  = 5'h11;
  localparam regAddrT addrTrig2  = 5'h12;
  localparam regAddrT addrTrig3  = 5'h13;
  localparam regAddrT addrConsol = 5'h1F;

endpackage

/* logic/gtiaTiming.sv */
//**************************************************
// GTIA timing: phi2 divider, horizontal counter and sync
//**************************************************
`timescale 1ns/100ps

module gtiaTiming #(
  parameter int divBits = 2
) (
  input  logic            Fphi0,
  input  logic            resetN,
  input  gtiaPkg::anCodeT anCode,
  output logic            phi2,
  output gtiaPkg::hposT   hpos,
  output gtiaPkg::anCodeT anDelayed,
  output logic            cSync
);
  import gtiaPkg::*;

  logic [divBits-1:0] divCnt;

  // Free running divider, top bit is phi2
  always_ff @(posedge Fphi0 or negedge resetN) begin
    if (!resetN) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + divBits'(1);
    end
  end

  assign phi2 = divCnt[divBits-1];

  always_ff @(posedge Fphi0 or negedge resetN) begin
    if (!resetN) begin
      anDelayed <= anBackground;
      cSync     <= 1'b0;
      hpos      <= '0;
    end else begin
      anDelayed <= anCode;
      cSync     <= (anCode == anHsync) || (anCode == anVsync);
      // Restart one cycle after the hsync code was sampled
      if (anDelayed == anHsync) begin
        hpos <= '0;
      end else begin
        hpos <= hpos + hposT'(1);
      end
    end
  end

  hposRestart: assert property (
    @(posedge Fphi0) disable iff (!resetN)
    (anCode == anHsync) |-> ##2 (hpos == '0)
  );

endmodule

/* logic/gtiaRegs.sv */
//**************************************************
// GTIA CPU register file and read-back mux
//**************************************************
`timescale 1ns/100ps

module gtiaRegs (
  input  logic             Fphi0,
  input  logic             resetN,
  input  gtiaPkg::regAddrT address,
  input  logic [7:0]       dataIn,
  input  logic             chipSel,
  input  logic             readNotWrite,
  input  logic [3:0]       trigger,
  input  logic [3:0]       consoleSwitch,
  input  logic [3:0]       mPf [4],
  input  logic [3:0]       pPf [4],
  input  logic [3:0]       mPl [4],
  input  logic [3:0]       pPl [4],
  output logic [7:0]       dataOut,
  output gtiaPkg::hposT    hposP [4],
  output gtiaPkg::hposT    hposM [4],
  output gtiaPkg::sizeT    sizeP [4],
  output gtiaPkg::sizeT    sizeM [4],
  output logic [7:0]       grafP [4],
  output logic [1:0]       grafM [4],
  output gtiaPkg::colorT   colPm [4],
  output gtiaPkg::colorT   colPf [4],
  output gtiaPkg::colorT   colBk,
  output logic [7:0]       prior,
  output logic             hitClr
);
  import gtiaPkg::*;

  logic       wrEn;
  logic       hitWr;
  logic [7:0] sizeMReg;
  logic [7:0] grafMReg;
  logic [7:0] rdData;

  assign wrEn  = chipSel && !readNotWrite;
  assign hitWr = wrEn && (address == addrHitClr);

  always_ff @(posedge Fphi0 or negedge resetN) begin
    if (!resetN) begin
      for (int n = 0; n < 4; n++) begin
        hposP[n] <= '0;
        hposM[n] <= '0;
        sizeP[n] <= '0;
        grafP[n] <= '0;
        colPm[n] <= '0;
        colPf[n] <= '0;
      end
      sizeMReg <= '0;
      grafMReg <= '0;
      colBk    <= '0;
      prior    <= '0;
    end else if (wrEn) begin
      // Groups of four, not all aligned to the address bits
      for (int n = 0; n < 4; n++) begin
        if (address == addrHposP0 + regAddrT'(n)) hposP[n] <= dataIn;
        if (address == addrHposM0 + regAddrT'(n)) hposM[n] <= dataIn;
        if (address == addrSizeP0 + regAddrT'(n)) sizeP[n] <= dataIn[1:0];
        if (address == addrGrafP0 + regAddrT'(n)) grafP[n] <= dataIn;
        if (address == addrColPm0 + regAddrT'(n)) colPm[n] <= dataIn;
        if (address == addrColPf0 + regAddrT'(n)) colPf[n] <= dataIn;
      end
      case (address)
        addrSizeM: sizeMReg <= dataIn;
        addrGrafM: grafMReg <= dataIn;
        addrColBk: colBk    <= dataIn;
        addrPrior: prior    <= dataIn;
        default:   ;
      endcase
    end
  end

  // Single cycle pulse towards collision logic
  always_ff @(posedge Fphi0 or negedge resetN) begin
    if (!resetN) begin
      hitClr <= 1'b0;
    end else begin
      hitClr <= hitWr;
    end
  end

  // Two bits per missile, M0 in the low bits
  for (genvar n = 0; n < 4; n++) begin : gMissile
    assign sizeM[n] = sizeMReg[2*n +: 2];
    assign grafM[n] = grafMReg[2*n +: 2];
  end

  always_comb begin
    rdData = '0;
    case (address[4:2])
      addrM0Pf[4:2]:  rdData = {4'b0, mPf[address[1:0]]};
      addrP0Pf[4:2]:  rdData = {4'b0, pPf[address[1:0]]};
      addrM0Pl[4:2]:  rdData = {4'b0, mPl[address[1:0]]};
      addrP0Pl[4:2]:  rdData = {4'b0, pPl[address[1:0]]};
      addrTrig0[4:2]: rdData = {7'b0, trigger[address[1:0]]};
      default: begin
        // PAL and unused addresses read zero
        if (address == addrConsol) rdData = {4'b0, consoleSwitch};
      end
    endcase
  end

  assign dataOut = (chipSel && readNotWrite) ? rdData : '0;

endmodule

/* playerMissile/pmGraphics.sv */
//**************************************************
// Player or missile object, position match and shifter
//**************************************************
`timescale 1ns/100ps

module pmGraphics #(
  parameter int objWidth = 8
) (
  input  logic                Fphi0,
  input  logic                resetN,
  input  gtiaPkg::hposT       hpos,
  input  gtiaPkg::hposT       position,
  input  gtiaPkg::sizeT       size,
  input  logic [objWidth-1:0] graphics,
  output logic                pixel
);
  import gtiaPkg::*;

  localparam int cntBits = $clog2(objWidth + 1);

  logic                matchQ;
  logic [cntBits-1:0]  bitsLeft;
  logic [1:0]          holdCnt;
  logic [1:0]          lastHold;
  logic [objWidth-1:0] shiftReg;

  // Cycles per bit minus one
  always_comb begin
    case (size)
      2'b01:   lastHold = 2'd1;
      2'b11:   lastHold = 2'd3;
      default: lastHold = 2'd0;
    endcase
  end

  always_ff @(posedge Fphi0 or negedge resetN) begin
    if (!resetN) begin
      matchQ   <= 1'b0;
      bitsLeft <= '0;
      holdCnt  <= '0;
    end else begin
      matchQ <= (hpos == position);
      // A new match restarts even a running object
      if (matchQ) begin
        bitsLeft <= cntBits'(objWidth);
        holdCnt  <= '0;
      end else if (bitsLeft != '0) begin
        if (holdCnt == lastHold) begin
          holdCnt  <= '0;
          bitsLeft <= bitsLeft - cntBits'(1);
        end else begin
          holdCnt <= holdCnt + 2'd1;
        end
      end
    end
  end

  always_ff @(posedge Fphi0) begin
    if (matchQ) begin
      shiftReg <= graphics;
    end else if (bitsLeft != '0 && holdCnt == lastHold) begin
      shiftReg <= shiftReg << 1;
    end
  end

  assign pixel = (bitsLeft != '0) && shiftReg[objWidth-1];

endmodule

/* logic/collisionDetect.sv */
//**************************************************
// Latched object collisions, cleared by HITCLR
//**************************************************
`timescale 1ns/100ps

module collisionDetect (
  input  logic            Fphi0,
  input  logic            resetN,
  input  logic [3:0]      playerPix,
  input  logic [3:0]      missilePix,
  input  gtiaPkg::anCodeT anDelayed,
  input  logic            hitClr,
  output logic [3:0]      mPf [4],
  output logic [3:0]      pPf [4],
  output logic [3:0]      mPl [4],
  output logic [3:0]      pPl [4]
);
  import gtiaPkg::*;

  logic [3:0] pfHit;

  // One-hot playfield index, none for background and sync codes
  always_comb begin
    pfHit = '0;
    if (anDelayed[2]) begin
      pfHit[anDelayed[1:0]] = 1'b1;
    end
  end

  always_ff @(posedge Fphi0 or negedge resetN) begin
    if (!resetN) begin
      for (int n = 0; n < 4; n++) begin
        mPf[n] <= '0;
        pPf[n] <= '0;
        mPl[n] <= '0;
        pPl[n] <= '0;
      end
    end else begin
      for (int n = 0; n < 4; n++) begin
        if (hitClr) begin
          mPf[n] <= '0;
          pPf[n] <= '0;
          mPl[n] <= '0;
          pPl[n] <= '0;
        end else begin
          if (missilePix[n]) mPf[n] <= mPf[n] | pfHit;
          if (playerPix[n])  pPf[n] <= pPf[n] | pfHit;
          if (missilePix[n]) mPl[n] <= mPl[n] | playerPix;
          // Other players only
          if (playerPix[n])  pPl[n] <= pPl[n] | (playerPix & ~(4'b0001 << n));
        end
      end
    end
  end

  for (genvar n = 0; n < 4; n++) begin : gSelf
    noSelfHit: assert property (
      @(posedge Fphi0) disable iff (!resetN) !pPl[n][n]
    );
  end

endmodule

/* logic/priorityMux.sv */
//**************************************************
// Colour priority between objects, playfield and background
//**************************************************
`timescale 1ns/100ps

module priorityMux (
  input  logic            Fphi0,
  input  logic            resetN,
  input  logic [3:0]      playerPix,
  input  logic [3:0]      missilePix,
  input  gtiaPkg::anCodeT anDelayed,
  input  gtiaPkg::colorT  colPm [4],
  input  gtiaPkg::colorT  colPf [4],
  input  gtiaPkg::colorT  colBk,
  input  logic [7:0]      prior,
  output gtiaPkg::colorT  colorOut
);
  import gtiaPkg::*;

  logic  objHit;
  logic  pfActive;
  logic  blanked;
  colorT objColor;
  colorT nextColor;

  // Lowest index wins, so scan downwards
  always_comb begin
    objHit   = 1'b0;
    objColor = '0;
    for (int n = 3; n >= 0; n--) begin
      if (playerPix[n] || missilePix[n]) begin
        objHit   = 1'b1;
        objColor = colPm[n];
      end
    end
  end

  assign pfActive = anDelayed[2];
  assign blanked  = (anDelayed == anVsync) || (anDelayed == anHsync) ||
                    (anDelayed == anBlank);

  always_comb begin
    if (blanked) begin
      nextColor = '0;
    end else if (pfActive && (prior[2] || !objHit)) begin
      nextColor = colPf[anDelayed[1:0]];
    end else if (objHit) begin
      nextColor = objColor;
    end else begin
      nextColor = colBk;
    end
  end

  always_ff @(posedge Fphi0 or negedge resetN) begin
    if (!resetN) begin
      colorOut <= '0;
    end else begin
      colorOut <= nextColor;
    end
  end

  blankBlack: assert property (
    @(posedge Fphi0) disable iff (!resetN)
    (anDelayed == anBlank) |=> (colorOut == '0)
  );

endmodule

/* logic/gtia.sv */
//**************************************************
// GTIA top level, timing, registers, objects and colour
//**************************************************
`timescale 1ns/100ps

module gtia #(
  parameter int divBits = 2
) (
  input  logic             Fphi0,
  input  logic             resetN,
  input  gtiaPkg::regAddrT address,
  input  logic [7:0]       dataIn,
  input  logic             chipSel,
  input  logic             readNotWrite,
  input  gtiaPkg::anCodeT  anCode,
  input  logic [3:0]       trigger,
  input  logic [3:0]       consoleSwitch,
  output logic [7:0]       dataOut,
  output gtiaPkg::colorT   colorOut,
  output logic             cSync,
  output logic             phi2
);
  import gtiaPkg::*;

  localparam int playerBits  = 8;
  localparam int missileBits = 2;

  hposT       hpos;
  anCodeT     anDelayed;
  hposT       hposP [4];
  hposT       hposM [4];
  sizeT       sizeP [4];
  sizeT       sizeM [4];
  logic [7:0] grafP [4];
  logic [1:0] grafM [4];
  colorT      colPm [4];
  colorT      colPf [4];
  colorT      colBk;
  logic [7:0] prior;
  logic       hitClr;
  logic [3:0] playerPix;
  logic [3:0] missilePix;
  logic [3:0] mPf [4];
  logic [3:0] pPf [4];
  logic [3:0] mPl [4];
  logic [3:0] pPl [4];

  gtiaTiming #(.divBits(divBits)) i_gtiaTiming (
    .Fphi0, .resetN, .anCode, .phi2, .hpos, .anDelayed, .cSync
  );

  gtiaRegs i_gtiaRegs (
    .Fphi0, .resetN, .address, .dataIn, .chipSel, .readNotWrite,
    .trigger, .consoleSwitch, .mPf, .pPf, .mPl, .pPl, .dataOut,
    .hposP, .hposM, .sizeP, .sizeM, .grafP, .grafM,
    .colPm, .colPf, .colBk, .prior, .hitClr
  );

  for (genvar n = 0; n < 4; n++) begin : gObj
    pmGraphics #(.objWidth(playerBits)) i_player (
      .Fphi0, .resetN, .hpos, .position(hposP[n]), .size(sizeP[n]),
      .graphics(grafP[n]), .pixel(playerPix[n])
    );

    pmGraphics #(.objWidth(missileBits)) i_missile (
      .Fphi0, .resetN, .hpos, .position(hposM[n]), .size(sizeM[n]),
      .graphics(grafM[n]), .pixel(missilePix[n])
    );
  end

  collisionDetect i_collisionDetect (
    .Fphi0, .resetN, .playerPix, .missilePix, .anDelayed, .hitClr,
    .mPf, .pPf, .mPl, .pPl
  );

  priorityMux i_priorityMux (
    .Fphi0, .resetN, .playerPix, .missilePix, .anDelayed,
    .colPm, .colPf, .colBk, .prior, .colorOut
  );

endmodule

/* bench/gtiaTb.sv */
//**************************************************
// GTIA testbench with register, timing, object,
// priority and collision checks
//**************************************************
`timescale 1ns/100ps

module gtiaTb;
  import gtiaPkg::*;

  logic       Fphi0;
  logic       resetN;
  regAddrT    address;
  logic [7:0] dataIn;
  logic       chipSel;
  logic       readNotWrite;
  anCodeT     anCode;
  logic [3:0] trigger;
  logic [3:0] consoleSwitch;
  logic [7:0] dataOut;
  colorT      colorOut;
  logic       cSync;
  logic       phi2;

  int         checkErrors;
  int         timeoutErrors;
  int         cycleCnt = 0;
  logic [7:0] expData;
  colorT      expDrive;
  colorT      expD1 = '0;
  colorT      expD2 = '0;
  anCodeT     prevCode = anBackground;
  colorT      colPmExp [4];
  colorT      colPfExp [4];
  colorT      colBkExp;
  logic [7:0] priorExp;
  // Display window per object in scan line code indices, missiles in 4 to 7
  int         winLo [8];
  int         winHi [8];
  anCodeT     lineCode [256];

  gtia i_gtia (
    .Fphi0, .resetN, .address, .dataIn, .chipSel, .readNotWrite, .anCode,
    .trigger, .consoleSwitch, .dataOut, .colorOut, .cSync, .phi2
  );

  initial begin
    Fphi0 = 1'b0;
    forever begin
      #20 Fphi0 = ~Fphi0;
    end
  end

  // Expected colour is set at drive time and appears two edges later
  always @(posedge Fphi0) begin
    expD1    <= expDrive;
    expD2    <= expD1;
    prevCode <= anCode;
    if (resetN) begin
      cycleCnt <= cycleCnt + 1;
    end
  end

  colorCheck: assert property (@(posedge Fphi0) disable iff (!resetN) colorOut == expD2)
    else begin
      checkErrors++;
      $display("CHECK FAILED colorOut: got %h, expected %h", $sampled(colorOut),
               $sampled(expD2));
    end

  dataCheck: assert property (@(posedge Fphi0) disable iff (!resetN) dataOut == expData)
    else begin
      checkErrors++;
      $display("CHECK FAILED dataOut: got %h, expected %h at address %h",
               $sampled(dataOut), $sampled(expData), $sampled(address));
    end

  syncCheck: assert property (@(posedge Fphi0) disable iff (!resetN)
    cSync == (prevCode == anHsync || prevCode == anVsync))
    else begin
      checkErrors++;
      $display("CHECK FAILED cSync: got %h, expected %h", $sampled(cSync),
               $sampled(prevCode == anHsync || prevCode == anVsync));
    end

  // Fphi0 divided by 4, low for the first two cycles
  phiCheck: assert property (@(posedge Fphi0) disable iff (!resetN)
    phi2 == ((cycleCnt % 4) >= 2))
    else begin
      checkErrors++;
      $display("CHECK FAILED phi2: got %h, expected %h", $sampled(phi2),
               $sampled((cycleCnt % 4) >= 2));
    end

  task automatic stepCycle();
    @(posedge Fphi0);
    #5;
  endtask

  task automatic idleCycles(input int count);
    repeat (count) stepCycle();
  endtask

  task automatic finishRun();
    $display("Check errors: %0d, timeouts: %0d", checkErrors, timeoutErrors);
    if (checkErrors == 0 && timeoutErrors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  task automatic writeReg(input regAddrT a, input logic [7:0] d);
    address      = a;
    dataIn       = d;
    chipSel      = 1'b1;
    readNotWrite = 1'b0;
    expData      = '0;
    for (int n = 0; n < 4; n++) begin
      if (a == addrColPm0 + regAddrT'(n)) colPmExp[n] = d;
      if (a == addrColPf0 + regAddrT'(n)) colPfExp[n] = d;
    end
    if (a == addrColBk) colBkExp = d;
    if (a == addrPrior) priorExp = d;
    stepCycle();
    chipSel      = 1'b0;
    readNotWrite = 1'b1;
  endtask

  task automatic readReg(input regAddrT a, input logic [7:0] expected);
    address      = a;
    chipSel      = 1'b1;
    readNotWrite = 1'b1;
    expData      = expected;
    stepCycle();
    chipSel = 1'b0;
    expData = '0;
  endtask

  function automatic int sizeFactor(input sizeT s);
    if (s == 2'b01) return 2;
    if (s == 2'b11) return 4;
    return 1;
  endfunction

  // Hpos is 0 at code 1, the match is sampled one edge later, the pixel the next
  task automatic setObject(input int slot, input int pos, input int width,
                           input int factor);
    winLo[slot] = pos + 3;
    winHi[slot] = pos + 2 + width * factor;
  endtask

  task automatic clearObjects();
    for (int n = 0; n < 8; n++) begin
      winLo[n] = 1;
      winHi[n] = 0;
    end
  endtask

  task automatic fillCodes(input int lo, input int hi, input anCodeT code);
    for (int i = lo; i <= hi; i++) begin
      lineCode[i] = code;
    end
  endtask

  function automatic logic objActive(input int slot, input int i);
    return (i >= winLo[slot]) && (i <= winHi[slot]);
  endfunction

  function automatic colorT expectedColor(input anCodeT code, input int i);
    int obj;
    obj = -1;
    for (int n = 0; n < 4; n++) begin
      if (obj < 0 && (objActive(n, i) || objActive(n + 4, i))) obj = n;
    end
    if (code == anVsync || code == anHsync || code == anBlank) return '0;
    if (code[2] && (priorExp[2] || obj < 0)) return colPfExp[code[1:0]];
    if (obj >= 0) return colPmExp[obj];
    return colBkExp;
  endfunction

  task automatic driveCode(input anCodeT code, input int i);
    anCode   = code;
    expDrive = expectedColor(code, i);
    stepCycle();
  endtask

  // Hsync run flushes old objects, its last cycle starts the line
  task automatic runLine(input int len);
    for (int i = 0; i < 40; i++) begin
      driveCode(anHsync, 0);
    end
    for (int i = 1; i <= len; i++) begin
      driveCode(lineCode[i], i);
    end
    anCode   = anHsync;
    expDrive = '0;
  endtask

  task automatic waitForSync(input int limit);
    int n;
    n = 0;
    while (!cSync && n < limit) begin
      stepCycle();
      n++;
    end
    if (!cSync) begin
      $display("Timeout: cSync did not rise after the first hsync code");
      timeoutErrors++;
    end
  endtask

  task automatic waitForPhi2(input int limit);
    int n;
    n = 0;
    while (!phi2 && n < limit) begin
      stepCycle();
      n++;
    end
    if (!phi2) begin
      $display("Timeout: phi2 never went high");
      timeoutErrors++;
    end
  endtask

  task automatic runChecks();
    // Triggers and console switches
    for (int k = 0; k < 8; k++) begin
      trigger       = 4'($urandom);
      consoleSwitch = 4'($urandom);
      for (int n = 0; n < 4; n++) begin
        readReg(addrTrig0 + regAddrT'(n), {7'b0, trigger[n]});
      end
      readReg(addrConsol, {4'b0, consoleSwitch});
      idleCycles(1);
    end

    writeReg(addrColBk, 8'h02);
    writeReg(addrColPm0, 8'h46);
    writeReg(addrColPm1, 8'h88);
    writeReg(addrColPm2, 8'hC4);
    writeReg(addrColPm3, 8'hE6);
    writeReg(addrColPf0, 8'h14);
    writeReg(addrColPf1, 8'h28);
    writeReg(addrColPf2, 8'h3A);
    writeReg(addrColPf3, 8'h5C);

    // Player 0 width for every size code
    writeReg(addrHposP0, 8'd20);
    writeReg(addrGrafP0, 8'hFF);
    for (int s = 0; s < 4; s++) begin
      writeReg(addrSizeP0, 8'(s));
      clearObjects();
      setObject(0, 20, 8, sizeFactor(2'(s)));
      runLine(70);
    end

    // Playfield against player, then blank and vsync
    writeReg(addrSizeP0, 8'h00);
    writeReg(addrHposP0, 8'd30);
    clearObjects();
    setObject(0, 30, 8, 1);
    fillCodes(36, 45, anPf2);
    fillCodes(50, 53, anBlank);
    fillCodes(56, 56, anVsync);
    writeReg(addrPrior, 8'h00);
    runLine(64);
    writeReg(addrPrior, 8'h04);
    runLine(64);
    writeReg(addrPrior, 8'h00);

    // Players 0 and 1 overlap, missile 2 at 2x over playfield 1
    writeReg(addrHposP0, 8'd40);
    writeReg(addrHposP1, 8'd44);
    writeReg(addrGrafP1, 8'hFF);
    writeReg(addrHposM2, 8'd60);
    writeReg(addrSizeM, 8'h10);
    writeReg(addrGrafM, 8'h30);
    clearObjects();
    setObject(0, 40, 8, 1);
    setObject(1, 44, 8, 1);
    setObject(6, 60, 2, 2);
    fillCodes(0, 255, anBackground);
    fillCodes(62, 68, anPf1);
    writeReg(addrHitClr, 8'h00);
    idleCycles(2);
    runLine(80);
    readReg(addrP0Pl, 8'h02);
    readReg(addrP0Pl + regAddrT'(1), 8'h01);
    readReg(addrM0Pf + regAddrT'(2), 8'h02);
    writeReg(addrHitClr, 8'h00);
    idleCycles(1);
    for (int n = 0; n < 16; n++) begin
      readReg(regAddrT'(n), 8'h00);
    end

    idleCycles(4);
  endtask

  initial begin
    void'($urandom(32'h75b6_024a));
    checkErrors   = 0;
    timeoutErrors = 0;
    resetN        = 1'b0;
    address       = '0;
    dataIn        = '0;
    chipSel       = 1'b0;
    readNotWrite  = 1'b1;
    anCode        = anBackground;
    trigger       = '0;
    consoleSwitch = '0;
    expData       = '0;
    expDrive      = '0;
    colBkExp      = '0;
    priorExp      = '0;
    for (int n = 0; n < 4; n++) begin
      colPmExp[n] = '0;
      colPfExp[n] = '0;
    end
    clearObjects();
    fillCodes(0, 255, anBackground);
    repeat (2) @(posedge Fphi0);
    #5;
    resetN = 1'b1;
    // Idle on hsync keeps hpos at zero between lines
    anCode = anHsync;
    waitForSync(4);
    waitForPhi2(8);
    if (timeoutErrors == 0) begin
      runChecks();
    end
    finishRun();
  end

endmodule

/* verilog.f */
common/gtiaPkg.sv
logic/gtiaTiming.sv
logic/gtiaRegs.sv
playerMissile/pmGraphics.sv
logic/collisionDetect.sv
logic/priorityMux.sv
logic/gtia.sv
bench/gtiaTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the GTIA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module gtiaTb -Mdir obj_dir -f verilog.f

simOut=$(./obj_dir/VgtiaTb) || true
echo "$simOut"
if echo "$simOut" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
